//--- common/sd_cfg.svh
`ifndef SD_CFG_SVH
`define SD_CFG_SVH

// Sources feeding the round-robin arbiter
`define SD_INPUTS 4

// Sinks behind the mirror and width of the destination mask
`define SD_OUTPUTS 4

// Payload bits in one flit
`define SD_PAYLOAD_W 8

`endif

//--- common/sd_pkg.sv
`include "sd_cfg.svh"

package sd_pkg;

  // One flit on the merged channel
  // Mask sits above the payload in the packed word
  typedef struct packed {
    logic [`SD_OUTPUTS-1:0]   dst;      // One bit per sink
    logic [`SD_PAYLOAD_W-1:0] payload;  // Copied to every masked sink
  } flit_t;

  // Occupancy of the one-flit mirror stage
  typedef enum logic {
    MS_EMPTY   = 1'b0,  // Nothing held
    MS_DELIVER = 1'b1   // Copies still owed to some sinks
  } mirror_state_t;

endpackage

//--- rrmux/sd_rrmux.sv
`timescale 1ns/100ps
`include "sd_cfg.svh"

// Round-robin merge of the sources onto one srdy/drdy channel
// Fully combinational in the data path, only the pointer is a flop
module sd_rrmux
  (
  input  logic                  clk,
  input  logic                  reset,
  // Sources
  input  logic [`SD_INPUTS-1:0] in_srdy,
  input  sd_pkg::flit_t         in_data [`SD_INPUTS],
  output logic [`SD_INPUTS-1:0] in_drdy,
  // Merged channel toward the mirror
  output logic                  mm_srdy,
  output sd_pkg::flit_t         mm_flit,
  input  logic                  mm_drdy
  );

  import sd_pkg::*;

  localparam int PTR_W  = $clog2(`SD_INPUTS);  // Index width
  localparam int FLIT_W = $bits(flit_t);

  logic [PTR_W-1:0]      last_ptr;   // Last input that completed a transfer
  logic [PTR_W-1:0]      grant_idx;  // Winner this cycle
  logic                  grant_vld;  // At least one source requesting
  logic [`SD_INPUTS-1:0] grant_oh;   // Winner as one-hot
  logic                  xfer;       // Merged transfer this cycle
  flit_t                 sel_flit;   // Winner's flit

  // Rotating priority search
  // Starts one above the last grant and wraps around to it
  always_comb
  begin : search
    int idx;
    grant_vld = 1'b0;
    grant_idx = last_ptr;  // Don't care when nobody asks
    for (int i = 1; i <= `SD_INPUTS; i++)
    begin
      idx = (int'(last_ptr) + i) % `SD_INPUTS;  // Wrap past the top input
      if (!grant_vld && in_srdy[idx])
      begin
        grant_vld = 1'b1;  // First hit wins
        grant_idx = PTR_W'(idx);
      end
    end
  end

  // Winner index to one-hot
  always_comb
  begin
    grant_oh = '0;
    if (grant_vld)
      grant_oh[grant_idx] = 1'b1;
  end

  // AND-OR data mux
  // Only the winner's lane survives the mask
  always_comb
  begin : mux_sel
    logic [FLIT_W-1:0] acc;
    acc = '0;
    for (int i = 0; i < `SD_INPUTS; i++)
      acc = acc | (in_data[i] & {FLIT_W{grant_oh[i]}});
    sel_flit = flit_t'(acc);
  end

  assign mm_srdy = grant_vld;  // Zero cycles from in_srdy
  assign mm_flit = sel_flit;

  // Ready goes back to the granted source alone
  assign in_drdy = grant_oh & {`SD_INPUTS{mm_drdy}};

  assign xfer = mm_srdy & mm_drdy;

  // Pointer moves only on a completed transfer
  // Reset value makes input 0 the first choice
  always_ff @(posedge clk)
  begin
    if (reset)
      last_ptr <= PTR_W'(`SD_INPUTS - 1);
    else if (xfer)
      last_ptr <= grant_idx;  // Re-arbitrate after every flit
  end

endmodule

//--- mirror/sd_mirror.sv
`timescale 1ns/100ps
`include "sd_cfg.svh"

// One-flit holding stage
// Offers the payload to every sink named in the mask
// Each sink takes its copy independently
module sd_mirror
  (
  input  logic                     clk,
  input  logic                     reset,
  // Merged channel from the arbiter
  input  logic                     mm_srdy,
  input  sd_pkg::flit_t            mm_flit,
  output logic                     mm_drdy,
  // Sinks
  output logic [`SD_OUTPUTS-1:0]   out_srdy,
  output logic [`SD_PAYLOAD_W-1:0] out_data,   // Shared by all sinks
  input  logic [`SD_OUTPUTS-1:0]   out_drdy
  );

  import sd_pkg::*;

  mirror_state_t            state;      // Held flit or not
  mirror_state_t            state_nxt;
  logic [`SD_OUTPUTS-1:0]   pend;       // Sinks still owed a copy
  logic [`SD_OUTPUTS-1:0]   pend_nxt;
  logic [`SD_OUTPUTS-1:0]   pend_left;  // Still owed after this cycle's accepts
  logic [`SD_PAYLOAD_W-1:0] payload_q;  // Held payload
  logic                     last_copy;  // Final owed copy goes out now
  logic                     load;       // Merged transfer this cycle
  logic                     keep;       // Loaded flit names some sink

  assign pend_left = pend & ~out_drdy;  // Bits clear as sinks accept
  assign last_copy = (state == MS_DELIVER) && (pend_left == '0);

  // Ready when empty or when the last copy leaves
  // Lets back-to-back flits flow with no bubble
  assign mm_drdy = (state == MS_EMPTY) || last_copy;

  assign load = mm_srdy && mm_drdy;
  assign keep = load && (mm_flit.dst != '0);  // Zero mask is swallowed

  // Next state and pending mask
  always_comb
  begin
    state_nxt = state;
    pend_nxt  = pend;
    case (state)
      MS_EMPTY:
      begin
        if (keep)
        begin
          state_nxt = MS_DELIVER;
          pend_nxt  = mm_flit.dst;  // One copy owed per mask bit
        end
      end
      MS_DELIVER:
      begin
        pend_nxt = pend_left;
        if (keep)
          pend_nxt = mm_flit.dst;  // Old flit done, new one in same cycle
        else if (last_copy)
          state_nxt = MS_EMPTY;
      end
      default:
      begin
        state_nxt = MS_EMPTY;
        pend_nxt  = '0;
      end
    endcase
  end

  // Control state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= MS_EMPTY;
      pend  <= '0;
    end
    else
    begin
      state <= state_nxt;
      pend  <= pend_nxt;
    end
  end

  // Payload register
  always_ff @(posedge clk)
  begin
    if (keep)
      payload_q <= mm_flit.payload;  // Held until every copy is taken
  end

  // Offer only to sinks that still owe
  assign out_srdy = (state == MS_DELIVER) ? pend : '0;
  assign out_data = payload_q;

endmodule

//--- logic/sd_switch.sv
`timescale 1ns/100ps
`include "sd_cfg.svh"

// Switch slice
// Arbitrate the sources onto one channel, then fan out to the sinks
// One cycle from an input transfer to the first output offer
module sd_switch
  (
  input  logic                     clk,
  input  logic                     reset,
  // Sources
  input  logic [`SD_INPUTS-1:0]    in_srdy,
  input  sd_pkg::flit_t            in_data [`SD_INPUTS],
  output logic [`SD_INPUTS-1:0]    in_drdy,
  // Sinks
  output logic [`SD_OUTPUTS-1:0]   out_srdy,
  output logic [`SD_PAYLOAD_W-1:0] out_data,
  input  logic [`SD_OUTPUTS-1:0]   out_drdy
  );

  import sd_pkg::*;

  logic  mm_srdy;  // Arbiter has a flit
  logic  mm_drdy;  // Mirror can take it
  flit_t mm_flit;  // Mask plus payload

  // Rotating priority merge
  sd_rrmux i_sd_rrmux
    (
    .clk     (clk),
    .reset   (reset),
    .in_srdy (in_srdy),
    .in_data (in_data),
    .in_drdy (in_drdy),
    .mm_srdy (mm_srdy),
    .mm_flit (mm_flit),
    .mm_drdy (mm_drdy)
    );

  // Registered fan-out
  sd_mirror i_sd_mirror
    (
    .clk      (clk),
    .reset    (reset),
    .mm_srdy  (mm_srdy),
    .mm_flit  (mm_flit),
    .mm_drdy  (mm_drdy),   // Stalls the arbiter under back-pressure
    .out_srdy (out_srdy),
    .out_data (out_data),
    .out_drdy (out_drdy)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

// Free-running testbench clock and power-on reset
module tb_clock_gen
  (
  output logic clk,
  output logic reset
  );

  localparam int HALF_PERIOD = 4;  // 8 ns period

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset seen by the flops on four rising edges
  initial
  begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;  // Released off the edge
  end

endmodule

//--- testbench/sd_switch_asserts.sv
`timescale 1ns/100ps
`include "sd_cfg.svh"

// Handshake checks on the switch ports
module sd_switch_asserts
  (
  input logic                     clk,
  input logic                     reset,
  input logic [`SD_INPUTS-1:0]    in_srdy,
  input sd_pkg::flit_t            in_data [`SD_INPUTS],
  input logic [`SD_INPUTS-1:0]    in_drdy,
  input logic [`SD_OUTPUTS-1:0]   out_srdy,
  input logic [`SD_PAYLOAD_W-1:0] out_data,
  input logic [`SD_OUTPUTS-1:0]   out_drdy
  );

  import sd_pkg::*;

  int fail_count = 0;  // Read by the testbench

  drdy_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(in_drdy))
    else
    begin
      fail_count++;
      $error("More than one in_drdy high");
    end

  // Stalled source keeps its offer
  for (genvar i = 0; i < `SD_INPUTS; i++)
  begin : g_in
    in_hold: assert property (@(posedge clk) disable iff (reset)
      in_srdy[i] && !in_drdy[i] |=> in_srdy[i] && $stable(in_data[i]))
      else
      begin
        fail_count++;
        $error("Input %0d dropped or changed a stalled flit", i);
      end
  end

  // Stalled sink sees the same payload
  for (genvar j = 0; j < `SD_OUTPUTS; j++)
  begin : g_out
    out_hold: assert property (@(posedge clk) disable iff (reset)
      out_srdy[j] && !out_drdy[j] |=> out_srdy[j] && $stable(out_data))
      else
      begin
        fail_count++;
        $error("Output %0d dropped or changed a stalled copy", j);
      end
  end

  reset_idle: assert property (@(posedge clk) reset |=> out_srdy == '0)
    else
    begin
      fail_count++;
      $error("out_srdy not idle after reset");
    end

endmodule

bind sd_switch sd_switch_asserts i_sd_switch_asserts (.*);

//--- testbench/bench_rrmux.sv
`timescale 1ns/100ps
`include "sd_cfg.svh"

// Switch slice testbench
// Random sources and sinks checked against a cycle model of arbiter and mirror
module bench_rrmux;

  import sd_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int RR_FLITS    = 8;   // Per source, all sinks ready
  localparam int BP_FLITS    = 6;   // Per source, one sink held off
  localparam int RND_FLITS   = 20;  // Per source, random sinks
  localparam int TOTAL_FLITS = `SD_INPUTS * (RR_FLITS + BP_FLITS + RND_FLITS);
  localparam int READY_ALL   = 0;
  localparam int HOLD_ONE    = 1;
  localparam int RANDOM      = 2;
  localparam logic [`SD_OUTPUTS-1:0] HELD_SINK = 4'b0010;  // Sink 1 under back-pressure

  logic                     clk;
  logic                     reset;
  logic [`SD_INPUTS-1:0]    in_srdy;
  flit_t                    in_data [`SD_INPUTS];
  logic [`SD_INPUTS-1:0]    in_drdy;
  logic [`SD_OUTPUTS-1:0]   out_srdy;
  logic [`SD_PAYLOAD_W-1:0] out_data;
  logic [`SD_OUTPUTS-1:0]   out_drdy;

  integer                   seed;
  int                       drdy_mode;                // Sink behavior for the phase
  int                       sent_cnt [`SD_INPUTS];    // Sequence count per source
  logic [`SD_PAYLOAD_W-1:0] exp_q [`SD_OUTPUTS][$];   // Payloads owed per sink
  logic [`SD_OUTPUTS-1:0]   ref_pend;                 // Model of copies still owed
  int                       ref_ptr;                  // Model of last grant
  bit                       seen_grant;

  tb_clock_gen i_tb_clock_gen (.clk(clk), .reset(reset));

  sd_switch i_sd_switch
    (
    .clk      (clk),
    .reset    (reset),
    .in_srdy  (in_srdy),
    .in_data  (in_data),
    .in_drdy  (in_drdy),
    .out_srdy (out_srdy),
    .out_data (out_data),
    .out_drdy (out_drdy)
    );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Rotating priority from the input above the last grant
  function automatic int next_grant(input int last, input logic [`SD_INPUTS-1:0] req);
    int idx;
    int winner;
    winner = last;
    for (int k = `SD_INPUTS; k >= 1; k--)  // Nearest requester written last
    begin
      idx = (last + k) % `SD_INPUTS;
      if (req[idx])
        winner = idx;
    end
    return winner;
  endfunction

  // One source sending count flits with random gaps up to gap_max cycles
  task automatic send_flits(input int src, input int count, input int gap_max);
    int    gap;
    int    rnd;
    logic  took;
    flit_t f;
    for (int n = 0; n < count; n++)
    begin
      rnd = $random(seed);
      gap = (gap_max == 0) ? 0 : (rnd & 'hff) % (gap_max + 1);
      if (gap > 0)
        in_srdy[src] = 1'b0;
      repeat (gap)
      begin
        @(posedge clk);
        #1;
      end
      rnd = $random(seed);
      f.dst = rnd[`SD_OUTPUTS-1:0];       // Often several sinks
      if (sent_cnt[src] % 7 == 3)
        f.dst = '0;                        // Should vanish in the mirror
      f.payload = {2'(src), 6'(sent_cnt[src])};
      sent_cnt[src]++;
      in_data[src] = f;
      in_srdy[src] = 1'b1;
      took = 1'b0;
      while (!took)
      begin
        @(negedge clk);
        took = in_drdy[src];  // Transfer at the coming edge
        @(posedge clk);
        #1;
      end
    end
    in_srdy[src] = 1'b0;
  endtask

  // Sink ready pattern, mode picked up at the edge
  initial
  begin : sink_drive
    int mode_now;
    int rnd;
    forever
    begin
      @(posedge clk);
      mode_now = drdy_mode;
      #1;
      rnd = $random(seed);
      case (mode_now)
        HOLD_ONE: out_drdy = ~HELD_SINK;
        RANDOM:   out_drdy = rnd[`SD_OUTPUTS-1:0];
        default:  out_drdy = '1;
      endcase
    end
  end

  // Model and compare, sampled mid-cycle where everything is settled
  always @(negedge clk)
  begin : compare_proc
    logic [`SD_OUTPUTS-1:0] pend_left;
    logic [`SD_INPUTS-1:0]  exp_drdy;
    int                     g;
    flit_t                  f;
    if (reset !== 1'b0)
    begin
      ref_pend   = '0;
      ref_ptr    = `SD_INPUTS - 1;  // Input 0 first after reset
      seen_grant = 1'b0;
    end
    else
    begin
      if (i_sd_switch.i_sd_switch_asserts.fail_count != 0)
        fail_run("A protocol assertion on the switch ports failed");
      check_val("out_srdy", out_srdy, ref_pend);  // Offer one cycle after accept
      for (int j = 0; j < `SD_OUTPUTS; j++)
      begin
        if (out_srdy[j] && out_drdy[j])
        begin
          if (exp_q[j].size() == 0)
            fail_run($sformatf("Sink %0d got a payload that nobody sent to it", j));
          else
            check_val($sformatf("out_data[%0d]", j), out_data, exp_q[j].pop_front());
        end
      end
      pend_left = ref_pend & ~out_drdy;
      g         = next_grant(ref_ptr, in_srdy);
      exp_drdy  = '0;
      if (pend_left == '0 && in_srdy != '0)
        exp_drdy[g] = 1'b1;  // Mirror free or freeing now
      check_val("in_drdy", in_drdy, exp_drdy);
      ref_pend = pend_left;
      if (exp_drdy != '0)
      begin
        if (!seen_grant)
          check_val("in_drdy", in_drdy, 1);  // Input 0 wins first after reset
        seen_grant = 1'b1;
        ref_ptr    = g;
        f          = in_data[g];
        ref_pend   = f.dst;
        for (int j = 0; j < `SD_OUTPUTS; j++)
          if (f.dst[j])
            exp_q[j].push_back(f.payload);
      end
    end
  end

  // Watchdog
  initial
  begin
    #(TOTAL_FLITS * 40 * CLK_PERIOD);
    fail_run($sformatf("Timeout after %0d ns with flits still in flight",
                       TOTAL_FLITS * 40 * CLK_PERIOD));
  end

  initial
  begin : main_seq
    int leftover;
    seed      = 35;
    drdy_mode = READY_ALL;
    in_srdy   = '0;
    out_drdy  = '1;
    for (int i = 0; i < `SD_INPUTS; i++)
    begin
      in_data[i]  = '0;
      sent_cnt[i] = 0;
    end
    @(negedge reset);
    @(posedge clk);
    #1;
    // All sources at once, rotation from input 0
    fork
      send_flits(0, RR_FLITS, 0);
      send_flits(1, RR_FLITS, 0);
      send_flits(2, RR_FLITS, 0);
      send_flits(3, RR_FLITS, 0);
    join
    // Sink 1 stalls the whole chain for a while
    drdy_mode = HOLD_ONE;
    fork
      send_flits(0, BP_FLITS, 2);
      send_flits(1, BP_FLITS, 2);
      send_flits(2, BP_FLITS, 2);
      send_flits(3, BP_FLITS, 2);
    join_none
    repeat (30) @(posedge clk);
    #1;
    drdy_mode = READY_ALL;
    wait fork;
    // Random gaps and random sinks
    drdy_mode = RANDOM;
    fork
      send_flits(0, RND_FLITS, 3);
      send_flits(1, RND_FLITS, 3);
      send_flits(2, RND_FLITS, 3);
      send_flits(3, RND_FLITS, 3);
    join
    drdy_mode = READY_ALL;
    wait (out_srdy == '0);  // Mirror empty, every copy taken
    @(negedge clk);
    #1;
    leftover = 0;
    for (int j = 0; j < `SD_OUTPUTS; j++)
      leftover += exp_q[j].size();
    if (leftover != 0)
      fail_run($sformatf("%0d payloads were never delivered to their sinks", leftover));
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- list.f
+incdir+common
common/sd_pkg.sv
rrmux/sd_rrmux.sv
mirror/sd_mirror.sv
logic/sd_switch.sv
testbench/tb_clock_gen.sv
testbench/sd_switch_asserts.sv
testbench/bench_rrmux.sv

//--- Bender.yml
package:
  name: sd_switch

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sd_pkg.sv
      - rrmux/sd_rrmux.sv
      - mirror/sd_mirror.sv
      - logic/sd_switch.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sd_switch_asserts.sv
      - testbench/bench_rrmux.sv
